//--- verilog/sched_pkg.sv
// Memory scheduler shared definitions
`default_nettype none

package sched_pkg;

  localparam int unsigned ADDR_W      = 32;
  localparam int unsigned LEN_W       = 16;
  localparam int unsigned ARRAY_WIDTH = 8;
  localparam int unsigned BEAT_BYTES  = 32;
  localparam int unsigned GIDX_W      = 8;

  // AXI4-Lite data path
  localparam int unsigned AXIL_DATA_W = 32;
  localparam int unsigned AXIL_STRB_W = AXIL_DATA_W / 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [LEN_W-1:0]  len_t;

  typedef struct packed {
    logic              skip;
    logic [GIDX_W-1:0] idx;
  } gidx_t;

  typedef struct packed {
    addr_t off;
    logic  skip;
  } offs_beat_t;

  typedef enum logic [1:0] {
    QINT_8 = 2'd0,
    QINT_4 = 2'd1,
    QINT_2 = 2'd2
  } qint_fmt_e;

  // Register byte offsets
  localparam addr_t REG_X_ADDR      = 32'h00;
  localparam addr_t REG_W_ADDR      = 32'h04;
  localparam addr_t REG_SCALES_ADDR = 32'h08;
  localparam addr_t REG_X_ITERS     = 32'h0C;
  localparam addr_t REG_W_ITERS     = 32'h10;
  localparam addr_t REG_X_ROWS_OFFS = 32'h14;
  localparam addr_t REG_W_D0_STRIDE = 32'h18;
  localparam addr_t REG_W_TOT_LEN   = 32'h1C;
  localparam addr_t REG_LEFTOVERS   = 32'h20;
  localparam addr_t REG_DEQUANT     = 32'h24;
  localparam addr_t REG_TOT_X_READ  = 32'h28;
  localparam addr_t REG_CTRL        = 32'h2C;

  // Stored registers sit below the control word
  localparam int unsigned NUM_REGS = REG_CTRL / 4;

endpackage

`default_nettype wire

//--- verilog/sched_cfg_if.sv
// Decoded scheduler configuration
`timescale 1ns/1ns
`default_nettype none

interface sched_cfg_if
  import sched_pkg::*;
();
  addr_t     x_addr, w_addr, scales_addr;
  len_t      x_cols_iters, x_rows_iters;
  len_t      w_iters, w_d0_len;
  addr_t     x_rows_offs, w_d0_stride;
  len_t      w_tot_len;
  logic [7:0] leftover_rows;
  logic      dequant_en;
  qint_fmt_e qint_fmt;
  len_t      tot_x_read;

  modport regs (
    output x_addr, w_addr, scales_addr, x_cols_iters, x_rows_iters, w_iters, w_d0_len,
           x_rows_offs, w_d0_stride, w_tot_len, leftover_rows, dequant_en, qint_fmt,
           tot_x_read
  );

  // Consumers only read the configuration
  modport reader (
    input x_addr, w_addr, scales_addr, x_cols_iters, x_rows_iters, w_iters, w_d0_len,
          x_rows_offs, w_d0_stride, w_tot_len, leftover_rows, dequant_en, qint_fmt,
          tot_x_read
  );
endinterface

`default_nettype wire

//--- verilog/cfg_regfile.sv
// AXI4-Lite configuration register file
`timescale 1ns/1ns
`default_nettype none

module cfg_regfile
  import sched_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  addr_t                  s_axil_awaddr_i,
  input  logic                   s_axil_awvalid_i,
  output logic                   s_axil_awready_o,
  input  logic [AXIL_DATA_W-1:0] s_axil_wdata_i,
  input  logic [AXIL_STRB_W-1:0] s_axil_wstrb_i,
  input  logic                   s_axil_wvalid_i,
  output logic                   s_axil_wready_o,
  output logic [1:0]             s_axil_bresp_o,
  output logic                   s_axil_bvalid_o,
  input  logic                   s_axil_bready_i,
  input  addr_t                  s_axil_araddr_i,
  input  logic                   s_axil_arvalid_i,
  output logic                   s_axil_arready_o,
  output logic [AXIL_DATA_W-1:0] s_axil_rdata_o,
  output logic [1:0]             s_axil_rresp_o,
  output logic                   s_axil_rvalid_o,
  input  logic                   s_axil_rready_i,
  sched_cfg_if.regs              cfg,
  output logic                   start_o,
  output logic                   clear_o
);
  logic [AXIL_DATA_W-1:0] regs_q [NUM_REGS];

  logic                   aw_pend_q, w_pend_q, bvalid_q, rvalid_q;
  addr_t                  awaddr_q;
  logic [AXIL_DATA_W-1:0] wdata_q, rdata_q;
  logic [AXIL_STRB_W-1:0] wstrb_q;

  logic                   aw_hs, w_hs, ar_hs, do_write, ctrl_write;
  addr_t                  wr_addr;
  logic [AXIL_DATA_W-1:0] wr_data;
  logic [AXIL_STRB_W-1:0] wr_strb;

  assign s_axil_awready_o = ~aw_pend_q;
  assign s_axil_wready_o  = ~w_pend_q;
  assign aw_hs = s_axil_awvalid_i & s_axil_awready_o;
  assign w_hs  = s_axil_wvalid_i & s_axil_wready_o;

  // The channel accepted in this cycle bypasses its holding register
  assign wr_addr = aw_pend_q ? awaddr_q : s_axil_awaddr_i;
  assign wr_data = w_pend_q ? wdata_q : s_axil_wdata_i;
  assign wr_strb = w_pend_q ? wstrb_q : s_axil_wstrb_i;

  assign do_write   = (aw_pend_q | aw_hs) & (w_pend_q | w_hs) & ~bvalid_q;
  assign ctrl_write = do_write && wr_addr == REG_CTRL && wr_strb[0];

  assign start_o = ctrl_write & wr_data[0];
  assign clear_o = ctrl_write & wr_data[1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      aw_pend_q <= 1'b0;
      w_pend_q  <= 1'b0;
      bvalid_q  <= 1'b0;
    end else begin
      aw_pend_q <= (aw_pend_q | aw_hs) & ~do_write;
      w_pend_q  <= (w_pend_q | w_hs) & ~do_write;
      if (do_write) begin
        bvalid_q <= 1'b1;
      end else if (s_axil_bready_i) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      awaddr_q <= s_axil_awaddr_i;
    end
    if (w_hs) begin
      wdata_q <= s_axil_wdata_i;
      wstrb_q <= s_axil_wstrb_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (do_write && wr_addr[ADDR_W-1:2] < NUM_REGS) begin
      for (int b = 0; b < AXIL_STRB_W; b++) begin
        if (wr_strb[b]) begin
          regs_q[wr_addr[5:2]][b*8 +: 8] <= wr_data[b*8 +: 8];
        end
      end
    end
  end

  // Read channel, one outstanding request
  assign s_axil_arready_o = ~rvalid_q;
  assign ar_hs = s_axil_arvalid_i & s_axil_arready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else if (ar_hs) begin
      rvalid_q <= 1'b1;
    end else if (s_axil_rready_i) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      rdata_q <= (s_axil_araddr_i[ADDR_W-1:2] < NUM_REGS) ? regs_q[s_axil_araddr_i[5:2]] : '0;
    end
  end

  assign s_axil_bvalid_o = bvalid_q;
  assign s_axil_bresp_o  = 2'b00;
  assign s_axil_rvalid_o = rvalid_q;
  assign s_axil_rdata_o  = rdata_q;
  assign s_axil_rresp_o  = 2'b00;

  // Field decode
  assign cfg.x_addr        = regs_q[REG_X_ADDR[5:2]];
  assign cfg.w_addr        = regs_q[REG_W_ADDR[5:2]];
  assign cfg.scales_addr   = regs_q[REG_SCALES_ADDR[5:2]];
  assign cfg.x_cols_iters  = regs_q[REG_X_ITERS[5:2]][15:0];
  assign cfg.x_rows_iters  = regs_q[REG_X_ITERS[5:2]][31:16];
  assign cfg.w_iters       = regs_q[REG_W_ITERS[5:2]][15:0];
  assign cfg.w_d0_len      = regs_q[REG_W_ITERS[5:2]][31:16];
  assign cfg.x_rows_offs   = regs_q[REG_X_ROWS_OFFS[5:2]];
  assign cfg.w_d0_stride   = regs_q[REG_W_D0_STRIDE[5:2]];
  assign cfg.w_tot_len     = regs_q[REG_W_TOT_LEN[5:2]][LEN_W-1:0];
  assign cfg.leftover_rows = regs_q[REG_LEFTOVERS[5:2]][31:24];
  assign cfg.dequant_en    = regs_q[REG_DEQUANT[5:2]][0];
  assign cfg.qint_fmt      = qint_fmt_e'(regs_q[REG_DEQUANT[5:2]][2:1]);
  assign cfg.tot_x_read    = regs_q[REG_TOT_X_READ[5:2]][LEN_W-1:0];

endmodule

`default_nettype wire

//--- verilog/tile_sequencer.sv
// Tile iteration and start request control
`timescale 1ns/1ns
`default_nettype none

module tile_sequencer
  import sched_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       start_i,
  input  logic       clear_i,
  input  logic       x_done_i,
  input  logic       x_ready_start_i,
  input  logic       w_ready_start_i,
  input  logic       gidx_ready_start_i,
  sched_cfg_if.reader cfg,
  output logic       x_req_start_o,
  output logic       w_req_start_o,
  output logic       gidx_req_start_o,
  output logic       last_row_o,
  output addr_t      rows_offs_o,
  output addr_t      cols_offs_o
);
  len_t  cols_q, wpass_q, rows_q, rd_cnt_q, rd_cnt_nxt;
  addr_t cols_offs_q, rows_offs_q;
  logic  x_pend_q, w_pend_q, gidx_pend_q;
  logic  col_wrap, wpass_wrap, row_adv, row_wrap, x_more;

  assign col_wrap   = cols_q == LEN_W'(cfg.x_cols_iters - 1'b1);
  assign wpass_wrap = wpass_q == LEN_W'(cfg.w_iters - 1'b1);
  assign row_adv    = col_wrap & wpass_wrap;
  assign row_wrap   = rows_q == LEN_W'(cfg.x_rows_iters - 1'b1);

  assign rd_cnt_nxt = rd_cnt_q + 1'b1;
  assign x_more     = rd_cnt_nxt < cfg.tot_x_read;

  // Columns inside weight passes inside rows
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cols_q      <= '0;
      wpass_q     <= '0;
      rows_q      <= '0;
      cols_offs_q <= '0;
      rows_offs_q <= '0;
      rd_cnt_q    <= '0;
    end else if (clear_i) begin
      cols_q      <= '0;
      wpass_q     <= '0;
      rows_q      <= '0;
      cols_offs_q <= '0;
      rows_offs_q <= '0;
      rd_cnt_q    <= '0;
    end else if (x_done_i) begin
      rd_cnt_q    <= rd_cnt_nxt;
      cols_q      <= col_wrap ? '0 : cols_q + 1'b1;
      cols_offs_q <= col_wrap ? '0 : cols_offs_q + BEAT_BYTES;
      if (col_wrap) begin
        wpass_q <= wpass_wrap ? '0 : wpass_q + 1'b1;
      end
      if (row_adv) begin
        rows_q      <= row_wrap ? '0 : rows_q + 1'b1;
        rows_offs_q <= row_wrap ? '0 : rows_offs_q + cfg.x_rows_offs;
      end
    end
  end

  assign x_req_start_o    = x_pend_q & x_ready_start_i;
  assign w_req_start_o    = w_pend_q & w_ready_start_i;
  assign gidx_req_start_o = gidx_pend_q & gidx_ready_start_i;

  // A flag drops on the cycle its request is issued
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      x_pend_q    <= 1'b0;
      w_pend_q    <= 1'b0;
      gidx_pend_q <= 1'b0;
    end else if (clear_i) begin
      x_pend_q    <= 1'b0;
      w_pend_q    <= 1'b0;
      gidx_pend_q <= 1'b0;
    end else begin
      x_pend_q    <= (x_pend_q & ~x_req_start_o) | start_i | (x_done_i & x_more);
      w_pend_q    <= (w_pend_q & ~w_req_start_o) | start_i;
      gidx_pend_q <= (gidx_pend_q & ~gidx_req_start_o) | (start_i & cfg.dequant_en);
    end
  end

  assign last_row_o  = row_wrap;
  assign rows_offs_o = rows_offs_q;
  assign cols_offs_o = cols_offs_q;

endmodule

`default_nettype wire

//--- verilog/stream_desc_gen.sv
// X and W stream descriptors
`timescale 1ns/1ns
`default_nettype none

module stream_desc_gen
  import sched_pkg::*;
(
  sched_cfg_if.reader cfg,
  input  addr_t       rows_offs_i,
  input  addr_t       cols_offs_i,
  input  logic        last_row_i,
  output addr_t       x_base_addr_o,
  output len_t        x_tot_len_o,
  output addr_t       w_base_addr_o,
  output addr_t       w_d0_stride_o,
  output len_t        w_tot_len_o,
  output len_t        w_d0_len_o,
  output len_t        w_d1_len_o
);
  logic use_leftover;

  assign x_base_addr_o = cfg.x_addr + rows_offs_i + cols_offs_i;

  // Last row may be partial
  assign use_leftover = last_row_i && cfg.leftover_rows != '0;
  assign x_tot_len_o  = use_leftover ? LEN_W'(cfg.leftover_rows) : LEN_W'(ARRAY_WIDTH);

  // W stream fetches scales instead of weights when dequantising
  assign w_base_addr_o = cfg.dequant_en ? cfg.scales_addr : cfg.w_addr;
  assign w_d0_stride_o = cfg.dequant_en ? '0 : cfg.w_d0_stride;

  assign w_tot_len_o = cfg.w_tot_len;
  assign w_d0_len_o  = cfg.w_d0_len;
  assign w_d1_len_o  = cfg.w_iters;

endmodule

`default_nettype wire

//--- verilog/gidx_offset_unit.sv
// Group index to scales and zeros offsets
`timescale 1ns/1ns
`default_nettype none

module gidx_offset_unit
  import sched_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  sched_cfg_if.reader cfg,
  input  logic        gidx_valid_i,
  input  gidx_t       gidx_data_i,
  output logic        gidx_ready_o,
  output logic        off_valid_o,
  output offs_beat_t  scales_off_o,
  output offs_beat_t  zeros_off_o,
  input  logic        scales_ready_i,
  input  logic        zeros_ready_i
);
  logic [1:0] q_shift;
  addr_t      idx_ext, stride_ext;
  logic       valid_q, out_accept, in_hs;
  offs_beat_t scales_q, zeros_q;

  // Zeros are packed, several per byte for narrow formats
  always_comb begin
    case (cfg.qint_fmt)
      QINT_2:  q_shift = 2'd3;
      QINT_4:  q_shift = 2'd2;
      default: q_shift = 2'd1;
    endcase
  end

  assign idx_ext    = addr_t'(gidx_data_i.idx);
  assign stride_ext = addr_t'(cfg.w_d0_stride[15:0]);

  assign out_accept   = scales_ready_i & zeros_ready_i;
  assign gidx_ready_o = ~valid_q | out_accept;
  assign in_hs        = gidx_valid_i & gidx_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (in_hs) begin
      valid_q <= 1'b1;
    end else if (out_accept) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_hs) begin
      scales_q.off  <= idx_ext * stride_ext;
      scales_q.skip <= gidx_data_i.skip;
      zeros_q.off   <= idx_ext * (stride_ext >> q_shift);
      zeros_q.skip  <= gidx_data_i.skip;
    end
  end

  assign off_valid_o  = valid_q;
  assign scales_off_o = scales_q;
  assign zeros_off_o  = zeros_q;

endmodule

`default_nettype wire

//--- verilog/mem_scheduler_top.sv
// Memory scheduler top level
`timescale 1ns/1ns
`default_nettype none

module mem_scheduler_top
  import sched_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  addr_t                  s_axil_awaddr_i,
  input  logic                   s_axil_awvalid_i,
  output logic                   s_axil_awready_o,
  input  logic [AXIL_DATA_W-1:0] s_axil_wdata_i,
  input  logic [AXIL_STRB_W-1:0] s_axil_wstrb_i,
  input  logic                   s_axil_wvalid_i,
  output logic                   s_axil_wready_o,
  output logic [1:0]             s_axil_bresp_o,
  output logic                   s_axil_bvalid_o,
  input  logic                   s_axil_bready_i,
  input  addr_t                  s_axil_araddr_i,
  input  logic                   s_axil_arvalid_i,
  output logic                   s_axil_arready_o,
  output logic [AXIL_DATA_W-1:0] s_axil_rdata_o,
  output logic [1:0]             s_axil_rresp_o,
  output logic                   s_axil_rvalid_o,
  input  logic                   s_axil_rready_i,
  input  logic                   x_done_i,
  input  logic                   x_ready_start_i,
  input  logic                   w_ready_start_i,
  input  logic                   gidx_ready_start_i,
  output logic                   x_req_start_o,
  output logic                   w_req_start_o,
  output logic                   gidx_req_start_o,
  output addr_t                  x_base_addr_o,
  output len_t                   x_tot_len_o,
  output addr_t                  w_base_addr_o,
  output addr_t                  w_d0_stride_o,
  output len_t                   w_tot_len_o,
  output len_t                   w_d0_len_o,
  output len_t                   w_d1_len_o,
  input  logic                   gidx_valid_i,
  input  gidx_t                  gidx_data_i,
  output logic                   gidx_ready_o,
  output logic                   off_valid_o,
  output addr_t                  scales_off_o,
  output logic                   scales_skip_o,
  output addr_t                  zeros_off_o,
  output logic                   zeros_skip_o,
  input  logic                   scales_ready_i,
  input  logic                   zeros_ready_i
);
  logic       start, clear, last_row;
  addr_t      rows_offs, cols_offs;
  offs_beat_t scales_beat, zeros_beat;

  sched_cfg_if cfg_if ();

  cfg_regfile cfg_regfile_inst (
    .clk_i, .rst_ni,
    .s_axil_awaddr_i, .s_axil_awvalid_i, .s_axil_awready_o,
    .s_axil_wdata_i, .s_axil_wstrb_i, .s_axil_wvalid_i, .s_axil_wready_o,
    .s_axil_bresp_o, .s_axil_bvalid_o, .s_axil_bready_i,
    .s_axil_araddr_i, .s_axil_arvalid_i, .s_axil_arready_o,
    .s_axil_rdata_o, .s_axil_rresp_o, .s_axil_rvalid_o, .s_axil_rready_i,
    .cfg     (cfg_if.regs),
    .start_o (start),
    .clear_o (clear)
  );

  tile_sequencer tile_sequencer_inst (
    .clk_i, .rst_ni,
    .start_i     (start),
    .clear_i     (clear),
    .x_done_i, .x_ready_start_i, .w_ready_start_i, .gidx_ready_start_i,
    .cfg         (cfg_if.reader),
    .x_req_start_o, .w_req_start_o, .gidx_req_start_o,
    .last_row_o  (last_row),
    .rows_offs_o (rows_offs),
    .cols_offs_o (cols_offs)
  );

  stream_desc_gen stream_desc_gen_inst (
    .cfg         (cfg_if.reader),
    .rows_offs_i (rows_offs),
    .cols_offs_i (cols_offs),
    .last_row_i  (last_row),
    .x_base_addr_o, .x_tot_len_o,
    .w_base_addr_o, .w_d0_stride_o, .w_tot_len_o, .w_d0_len_o, .w_d1_len_o
  );

  gidx_offset_unit gidx_offset_unit_inst (
    .clk_i, .rst_ni,
    .cfg          (cfg_if.reader),
    .gidx_valid_i, .gidx_data_i, .gidx_ready_o, .off_valid_o,
    .scales_off_o (scales_beat),
    .zeros_off_o  (zeros_beat),
    .scales_ready_i, .zeros_ready_i
  );

  assign scales_off_o  = scales_beat.off;
  assign scales_skip_o = scales_beat.skip;
  assign zeros_off_o   = zeros_beat.off;
  assign zeros_skip_o  = zeros_beat.skip;

endmodule

`default_nettype wire

//--- test/tb_checks.svh
// Bus access and compare tasks
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic report_failure(input string why);
  $display("%s", why);
  $display("*** FAILED ***");
  $fatal(1, "Stopped at the first error");
endtask

task automatic check_addr(input string name, input addr_t exp, input addr_t act);
  if (act !== exp) begin
    report_failure($sformatf("[FAIL] %s expected 0x%h actual 0x%h", name, exp, act));
  end
endtask

task automatic check_len(input string name, input len_t exp, input len_t act);
  if (act !== exp) begin
    report_failure($sformatf("[FAIL] %s expected 0x%h actual 0x%h", name, exp, act));
  end
endtask

task automatic check_beat(input string name, input offs_beat_t exp, input offs_beat_t act);
  if (act !== exp) begin
    report_failure($sformatf("[FAIL] %s expected 0x%h actual 0x%h", name, exp, act));
  end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    report_failure($sformatf("[FAIL] %s expected 0x%h actual 0x%h", name, exp, act));
  end
endtask

task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
  if (act !== exp) begin
    report_failure($sformatf("[FAIL] %s expected 0x%h actual 0x%h", name, exp, act));
  end
endtask

// Address and data are offered together and each valid drops once accepted
task automatic axil_write(input addr_t addr, input logic [AXIL_DATA_W-1:0] data);
  logic aw_acc, w_acc;
  @(negedge clk_i);
  s_axil_awaddr_i  = addr;
  s_axil_awvalid_i = 1'b1;
  s_axil_wdata_i   = data;
  s_axil_wstrb_i   = '1;
  s_axil_wvalid_i  = 1'b1;
  s_axil_bready_i  = 1'b1;
  while (s_axil_awvalid_i || s_axil_wvalid_i) begin
    @(posedge clk_i);
    aw_acc = s_axil_awvalid_i & s_axil_awready_o;
    w_acc  = s_axil_wvalid_i & s_axil_wready_o;
    @(negedge clk_i);
    if (aw_acc) s_axil_awvalid_i = 1'b0;
    if (w_acc) s_axil_wvalid_i = 1'b0;
  end
  do begin
    @(posedge clk_i);
  end while (!s_axil_bvalid_o);
  check_resp("s_axil_bresp_o", 2'b00, s_axil_bresp_o);
  @(negedge clk_i);
  s_axil_bready_i = 1'b0;
endtask

task automatic axil_read(input addr_t addr, output logic [AXIL_DATA_W-1:0] data);
  @(negedge clk_i);
  s_axil_araddr_i  = addr;
  s_axil_arvalid_i = 1'b1;
  s_axil_rready_i  = 1'b1;
  do begin
    @(posedge clk_i);
  end while (!s_axil_arready_o);
  @(negedge clk_i);
  s_axil_arvalid_i = 1'b0;
  do begin
    @(posedge clk_i);
  end while (!s_axil_rvalid_o);
  data = s_axil_rdata_o;
  check_resp("s_axil_rresp_o", 2'b00, s_axil_rresp_o);
  @(negedge clk_i);
  s_axil_rready_i = 1'b0;
endtask

`endif

//--- test/tb_mem_scheduler.sv
// Memory scheduler testbench
`timescale 1ns/1ns
`default_nettype none

module tb_mem_scheduler
  import sched_pkg::*;
();
  typedef struct packed {
    len_t        cols;
    len_t        wpass;
    len_t        rows;
    addr_t       rows_offs;
    addr_t       d0_stride;
    logic [7:0]  leftover;
    logic        dequant;
    logic [1:0]  fmt;
    len_t        tot_x_read;
    logic [3:0]  n_gidx;
    logic [63:0] gidx_idx;
    logic [7:0]  gidx_skip;
  } case_t;

  localparam int NUM_CASES = 4;

  // Group index k sits in byte k of gidx_idx, its skip bit in bit k of gidx_skip
  localparam case_t CASES [NUM_CASES] = '{
    '{cols: 16'd2, wpass: 16'd1, rows: 16'd3, rows_offs: 32'h400, d0_stride: 32'h40,
      leftover: 8'd5, dequant: 1'b0, fmt: 2'd0, tot_x_read: 16'd6,
      n_gidx: 4'd4, gidx_idx: 64'h0000_0000_0903_0100, gidx_skip: 8'h04},
    '{cols: 16'd3, wpass: 16'd2, rows: 16'd2, rows_offs: 32'h1000, d0_stride: 32'h80,
      leftover: 8'd0, dequant: 1'b1, fmt: 2'd1, tot_x_read: 16'd13,
      n_gidx: 4'd8, gidx_idx: 64'h7F20_0C05_1102_FF00, gidx_skip: 8'h81},
    '{cols: 16'd1, wpass: 16'd3, rows: 16'd2, rows_offs: 32'h200, d0_stride: 32'h24,
      leftover: 8'd3, dequant: 1'b1, fmt: 2'd2, tot_x_read: 16'd4,
      n_gidx: 4'd6, gidx_idx: 64'h0000_3316_0807_0201, gidx_skip: 8'h12},
    '{cols: 16'd4, wpass: 16'd1, rows: 16'd1, rows_offs: 32'h800, d0_stride: 32'hFFFF_1038,
      leftover: 8'd7, dequant: 1'b1, fmt: 2'd3, tot_x_read: 16'd4,
      n_gidx: 4'd8, gidx_idx: 64'hC0A0_8060_4020_1000, gidx_skip: 8'hF0}
  };

  logic                   clk_i, rst_ni;
  addr_t                  s_axil_awaddr_i, s_axil_araddr_i;
  logic                   s_axil_awvalid_i, s_axil_awready_o, s_axil_wvalid_i, s_axil_wready_o;
  logic [AXIL_DATA_W-1:0] s_axil_wdata_i, s_axil_rdata_o;
  logic [AXIL_STRB_W-1:0] s_axil_wstrb_i;
  logic [1:0]             s_axil_bresp_o, s_axil_rresp_o;
  logic                   s_axil_bvalid_o, s_axil_bready_i, s_axil_arvalid_i, s_axil_arready_o;
  logic                   s_axil_rvalid_o, s_axil_rready_i;
  logic                   x_done_i, x_ready_start_i, w_ready_start_i, gidx_ready_start_i;
  logic                   x_req_start_o, w_req_start_o, gidx_req_start_o;
  addr_t                  x_base_addr_o, w_base_addr_o, w_d0_stride_o;
  len_t                   x_tot_len_o, w_tot_len_o, w_d0_len_o, w_d1_len_o;
  logic                   gidx_valid_i, gidx_ready_o, off_valid_o;
  gidx_t                  gidx_data_i;
  addr_t                  scales_off_o, zeros_off_o;
  logic                   scales_skip_o, zeros_skip_o, scales_ready_i, zeros_ready_i;

  // Reference tile walk
  len_t  m_cols, m_wp, m_rows;
  addr_t m_cols_offs, m_rows_offs;

  int x_req_cnt = 0;
  int w_req_cnt = 0;
  int gidx_req_cnt = 0;
  int seed = 27103;

  `include "tb_checks.svh"

  mem_scheduler_top mem_scheduler_top_inst (.*);

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    if (x_req_start_o) x_req_cnt++;
    if (w_req_start_o) w_req_cnt++;
    if (gidx_req_start_o) gidx_req_cnt++;
  end

  initial begin
    int max_done, limit;
    max_done = 0;
    for (int i = 0; i < NUM_CASES; i++) begin
      if (int'(CASES[i].tot_x_read) > max_done) max_done = int'(CASES[i].tot_x_read);
    end
    limit = NUM_CASES * max_done * 40;
    repeat (limit) @(posedge clk_i);
    report_failure($sformatf("Timeout: the test did not finish within %0d clock cycles", limit));
  end

  task automatic step_model(input case_t c);
    if (m_cols == c.cols - 1'b1) begin
      m_cols      = '0;
      m_cols_offs = '0;
      if (m_wp == c.wpass - 1'b1) begin
        m_wp = '0;
        if (m_rows == c.rows - 1'b1) begin
          m_rows      = '0;
          m_rows_offs = '0;
        end else begin
          m_rows      = m_rows + 1'b1;
          m_rows_offs = m_rows_offs + c.rows_offs;
        end
      end else begin
        m_wp = m_wp + 1'b1;
      end
    end else begin
      m_cols      = m_cols + 1'b1;
      m_cols_offs = m_cols_offs + BEAT_BYTES;
    end
  endtask

  task automatic check_x_desc(input case_t c, input addr_t x_addr);
    len_t exp_len;
    exp_len = len_t'(ARRAY_WIDTH);
    if (m_rows == c.rows - 1'b1 && c.leftover != 8'd0) exp_len = len_t'(c.leftover);
    check_addr("x_base_addr_o", x_addr + m_rows_offs + m_cols_offs, x_base_addr_o);
    check_len("x_tot_len_o", exp_len, x_tot_len_o);
  endtask

  // Random valid and ready, beats must come out in order
  task automatic run_gidx(input case_t c);
    int         n, sent, got, shift, rnd;
    logic       in_acc, out_acc;
    logic [7:0] idx;
    addr_t      stride;
    offs_beat_t exp_beat, act_beat;
    n      = int'(c.n_gidx);
    stride = addr_t'(c.d0_stride[15:0]);
    shift  = (c.fmt == QINT_2) ? 3 : (c.fmt == QINT_4) ? 2 : 1;
    sent   = 0;
    got    = 0;
    while (got < n) begin
      @(posedge clk_i);
      in_acc  = gidx_valid_i & gidx_ready_o;
      out_acc = off_valid_o & scales_ready_i & zeros_ready_i;
      if (out_acc) begin
        idx           = c.gidx_idx[got*8 +: 8];
        exp_beat.skip = c.gidx_skip[got];
        exp_beat.off  = addr_t'(idx) * stride;
        act_beat.off  = scales_off_o;
        act_beat.skip = scales_skip_o;
        check_beat("scales_off_o", exp_beat, act_beat);
        exp_beat.off  = addr_t'(idx) * (stride >> shift);
        act_beat.off  = zeros_off_o;
        act_beat.skip = zeros_skip_o;
        check_beat("zeros_off_o", exp_beat, act_beat);
        got++;
      end
      if (in_acc) sent++;
      @(negedge clk_i);
      if (!gidx_valid_i || in_acc) begin
        rnd = $random(seed);
        gidx_valid_i = (sent < n) && (rnd[0] | rnd[1]);
        if (sent < n) begin
          gidx_data_i.idx  = c.gidx_idx[sent*8 +: 8];
          gidx_data_i.skip = c.gidx_skip[sent];
        end
      end
      rnd = $random(seed);
      scales_ready_i = rnd[2] | rnd[3];
      zeros_ready_i  = rnd[4] | rnd[5];
    end
    gidx_valid_i   = 1'b0;
    scales_ready_i = 1'b0;
    zeros_ready_i  = 1'b0;
    check_bit("off_valid_o", 1'b0, off_valid_o);
  endtask

  task automatic run_case(input int i);
    case_t       c;
    addr_t       x_addr, w_addr, s_addr;
    addr_t       reg_addr [11];
    logic [31:0] reg_val [11];
    logic [31:0] rd;
    int          x0, w0, g0;
    c      = CASES[i];
    x_addr = 32'h1000_0000 + 32'(i) * 32'h0001_0000;
    w_addr = 32'h2000_0040 + 32'(i) * 32'h0002_0000;
    s_addr = 32'h3000_0080 + 32'(i) * 32'h0000_4000;
    reg_addr = '{REG_X_ADDR, REG_W_ADDR, REG_SCALES_ADDR, REG_X_ITERS, REG_W_ITERS,
                 REG_X_ROWS_OFFS, REG_W_D0_STRIDE, REG_W_TOT_LEN, REG_LEFTOVERS,
                 REG_DEQUANT, REG_TOT_X_READ};
    reg_val = '{x_addr, w_addr, s_addr, {c.rows, c.cols}, {16'(i + 4), c.wpass},
                c.rows_offs, c.d0_stride, 32'h100 + 32'(i), {c.leftover, 24'h00_5A3C},
                {29'd0, c.fmt, c.dequant}, {16'h0, c.tot_x_read}};
    for (int r = 0; r < 11; r++) axil_write(reg_addr[r], reg_val[r]);
    for (int r = 0; r < 11; r++) begin
      axil_read(reg_addr[r], rd);
      check_addr("s_axil_rdata_o", reg_val[r], rd);
    end
    axil_read(REG_CTRL, rd);
    check_addr("s_axil_rdata_o", '0, rd);

    // Clear the walk, then start the job with all streams busy
    axil_write(REG_CTRL, 32'h2);
    axil_write(REG_CTRL, 32'h1);
    x0 = x_req_cnt;
    w0 = w_req_cnt;
    g0 = gidx_req_cnt;
    m_cols      = '0;
    m_wp        = '0;
    m_rows      = '0;
    m_cols_offs = '0;
    m_rows_offs = '0;
    check_addr("w_base_addr_o", c.dequant ? s_addr : w_addr, w_base_addr_o);
    check_addr("w_d0_stride_o", c.dequant ? '0 : c.d0_stride, w_d0_stride_o);
    check_len("w_tot_len_o", 16'h100 + 16'(i), w_tot_len_o);
    check_len("w_d0_len_o", 16'(i + 4), w_d0_len_o);
    check_len("w_d1_len_o", c.wpass, w_d1_len_o);
    check_x_desc(c, x_addr);
    repeat (3) @(negedge clk_i);
    check_bit("w_req_start_o", 1'b0, w_req_start_o);
    check_bit("gidx_req_start_o", 1'b0, gidx_req_start_o);
    x_ready_start_i    = 1'b1;
    w_ready_start_i    = 1'b1;
    gidx_ready_start_i = 1'b1;
    #1;
    check_bit("x_req_start_o", 1'b1, x_req_start_o);
    check_bit("w_req_start_o", 1'b1, w_req_start_o);
    check_bit("gidx_req_start_o", c.dequant, gidx_req_start_o);
    repeat (4) @(negedge clk_i);
    check_len("w_req_start_o count", 16'd1, len_t'(w_req_cnt - w0));
    check_len("gidx_req_start_o count", len_t'(c.dequant), len_t'(gidx_req_cnt - g0));

    for (int k = 0; k < int'(c.tot_x_read); k++) begin
      @(negedge clk_i);
      x_done_i = 1'b1;
      @(negedge clk_i);
      x_done_i = 1'b0;
      step_model(c);
      check_x_desc(c, x_addr);
    end
    repeat (3) @(negedge clk_i);
    check_len("x_req_start_o count", c.tot_x_read, len_t'(x_req_cnt - x0));

    run_gidx(c);
    x_ready_start_i    = 1'b0;
    w_ready_start_i    = 1'b0;
    gidx_ready_start_i = 1'b0;
  endtask

  initial begin
    clk_i              = 1'b0;
    rst_ni             = 1'b0;
    s_axil_awaddr_i    = '0;
    s_axil_awvalid_i   = 1'b0;
    s_axil_wdata_i     = '0;
    s_axil_wstrb_i     = '0;
    s_axil_wvalid_i    = 1'b0;
    s_axil_bready_i    = 1'b0;
    s_axil_araddr_i    = '0;
    s_axil_arvalid_i   = 1'b0;
    s_axil_rready_i    = 1'b0;
    x_done_i           = 1'b0;
    x_ready_start_i    = 1'b0;
    w_ready_start_i    = 1'b0;
    gidx_ready_start_i = 1'b0;
    gidx_valid_i       = 1'b0;
    gidx_data_i        = '0;
    scales_ready_i     = 1'b0;
    zeros_ready_i      = 1'b0;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    check_bit("x_req_start_o", 1'b0, x_req_start_o);
    check_bit("w_req_start_o", 1'b0, w_req_start_o);
    check_bit("gidx_req_start_o", 1'b0, gidx_req_start_o);
    check_bit("off_valid_o", 1'b0, off_valid_o);
    check_bit("s_axil_bvalid_o", 1'b0, s_axil_bvalid_o);
    check_bit("s_axil_rvalid_o", 1'b0, s_axil_rvalid_o);
    for (int i = 0; i < NUM_CASES; i++) run_case(i);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+test
verilog/sched_pkg.sv
verilog/sched_cfg_if.sv
verilog/cfg_regfile.sv
verilog/tile_sequencer.sv
verilog/stream_desc_gen.sv
verilog/gidx_offset_unit.sv
verilog/mem_scheduler_top.sv
test/tb_mem_scheduler.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -Wno-fatal --top-module tb_mem_scheduler -f vlog.f
./obj_dir/Vtb_mem_scheduler > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** FAILED ***' sim.log; then
  exit 1
fi
if ! grep -qF '*** PASSED ***' sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
